//--- tb.f
l2_pkg.sv
l2_tag_array.sv
l2_data_array.sv
l2_plru.sv
l2_ctrl.sv
l2_port_arbiter.sv
l2_backing_mem.sv
l2_subsystem.sv
tb_l2_checker.sv
tb_l2_top.sv

//--- tb_l2_top.sv
module tb_l2_top;

    localparam int mem_latency = 4;
    localparam int num_txns = 400;
    localparam int clk_period = 20;
    localparam int reset_cycles = 8;
    localparam longint timeout_time =
        longint'(reset_cycles + num_txns * (2 * mem_latency + 12)) * clk_period;

    logic            clk;
    logic            rst_n;
    logic            i_req;
    l2_pkg::l1_req_t i_l1;
    logic            d_req;
    l2_pkg::l1_req_t d_l1;
    logic            i_addr_ok;
    logic            i_data_ok;
    l2_pkg::word_t   i_rdata;
    logic            d_addr_ok;
    logic            d_data_ok;
    l2_pkg::word_t   d_rdata;

    int            errors;
    int            checks;
    int            issued;
    logic [31:0]   lfsr_q;
    l2_pkg::addr_t last_addr [2];

    l2_subsystem u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_req     (i_req),
        .i_l1      (i_l1),
        .d_req     (d_req),
        .d_l1      (d_l1),
        .i_addr_ok (i_addr_ok),
        .i_data_ok (i_data_ok),
        .i_rdata   (i_rdata),
        .d_addr_ok (d_addr_ok),
        .d_data_ok (d_data_ok),
        .d_rdata   (d_rdata)
    );

    tb_l2_checker u_checker (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_req     (i_req),
        .i_l1      (i_l1),
        .d_req     (d_req),
        .d_l1      (d_l1),
        .i_addr_ok (i_addr_ok),
        .i_data_ok (i_data_ok),
        .i_rdata   (i_rdata),
        .d_addr_ok (d_addr_ok),
        .d_data_ok (d_data_ok),
        .d_rdata   (d_rdata),
        .errors    (errors),
        .checks    (checks)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    // Word aligned, inside the 64 backing lines
    function automatic l2_pkg::addr_t pick_addr(input int port);
        logic [1:0]    mode;
        l2_pkg::addr_t a;
        mode = 2'(take_bits(2));
        a = '0;
        case (mode)
            2'd0: begin
                // Hammer set 1 with up to 16 tags
                a[9:6] = 4'(take_bits(4));
                a[5:4] = 2'b01;
                a[3:2] = 2'(take_bits(2));
            end
            2'd1: a = last_addr[port];
            default: a[9:2] = 8'(take_bits(8));
        endcase
        last_addr[port] = a;
        return a;
    endfunction

    function automatic l2_pkg::l1_req_t make_req(input int port);
        l2_pkg::l1_req_t r;
        r = '0;
        r.addr = pick_addr(port);
        if (port == 1) begin
            r.wr = 1'(take_bits(1));
            if (r.wr) begin
                r.wdata = take_bits(32);
                r.wstrb = 4'(take_bits(4));
            end
        end
        return r;
    endfunction

    // Full handshake on one port, starting on a falling edge
    task automatic issue(input int port, input l2_pkg::l1_req_t r);
        logic accepted;
        logic finished;
        accepted = 1'b0;
        finished = 1'b0;
        if (port == 1) begin
            d_req = 1'b1;
            d_l1 = r;
        end else begin
            i_req = 1'b1;
            i_l1 = r;
        end
        while (!accepted) begin
            @(posedge clk);
            accepted = (port == 1) ? d_addr_ok : i_addr_ok;
        end
        @(negedge clk);
        if (port == 1) begin
            d_req = 1'b0;
            d_l1 = '0;
        end else begin
            i_req = 1'b0;
            i_l1 = '0;
        end
        while (!finished) begin
            @(posedge clk);
            finished = (port == 1) ? d_data_ok : i_data_ok;
        end
    endtask

    initial begin
        logic [1:0]      which;
        l2_pkg::l1_req_t ri;
        l2_pkg::l1_req_t rd;
        rst_n = 1'b0;
        i_req = 1'b0;
        d_req = 1'b0;
        i_l1 = '0;
        d_l1 = '0;
        lfsr_q = 32'h3fff;
        issued = 0;
        last_addr[0] = '0;
        last_addr[1] = '0;
        repeat (reset_cycles) @(negedge clk);
        rst_n = 1'b1;
        while (issued < num_txns) begin
            @(negedge clk);
            which = 2'(take_bits(2));
            case (which)
                2'b01: begin
                    ri = make_req(0);
                    issue(0, ri);
                    issued++;
                end
                2'b10: begin
                    rd = make_req(1);
                    issue(1, rd);
                    issued++;
                end
                2'b11: begin
                    // Both ports in the same cycle
                    ri = make_req(0);
                    rd = make_req(1);
                    fork
                        issue(0, ri);
                        issue(1, rd);
                    join
                    issued += 2;
                end
                default: ;
            endcase
        end
        @(negedge clk);
        $display("transactions %0d, checks %0d, errors %0d", issued, checks, errors);
        if (errors == 0 && checks > 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #(timeout_time);
        $display("Timeout: the run did not finish within %0d time units", timeout_time);
        $display("transactions %0d, checks %0d, errors %0d", issued, checks, errors);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

//--- tb_l2_checker.sv
module tb_l2_checker (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            i_req,
    input  l2_pkg::l1_req_t i_l1,
    input  logic            d_req,
    input  l2_pkg::l1_req_t d_l1,
    input  logic            i_addr_ok,
    input  logic            i_data_ok,
    input  l2_pkg::word_t   i_rdata,
    input  logic            d_addr_ok,
    input  logic            d_data_ok,
    input  l2_pkg::word_t   d_rdata,
    output int              errors,
    output int              checks
);

    // Word model over the 64 lines of backing memory, index is addr[9:2]
    l2_pkg::word_t   model [256] = '{default: '0};
    l2_pkg::l1_req_t pend_req [2] = '{default: '0};
    logic            pend [2] = '{default: 1'b0};
    logic            expect_hit [2] = '{default: 1'b0};
    int              accept_cycle [2] = '{default: 0};

    int          err_q = 0;
    int          check_q = 0;
    int          cycle = 0;
    logic [27:0] last_line = '0;
    logic        last_valid = 1'b0;

    assign errors = err_q;
    assign checks = check_q;

    function automatic string port_name(input int p);
        return (p == 1) ? "data" : "instruction";
    endfunction

    task automatic note_accept(input int p, input l2_pkg::l1_req_t r);
        logic [27:0] line_a;
        line_a = r.addr[31:4];
        check_q++;
        if (pend[p]) begin
            err_q++;
            $display("error at %0t: %s port addr_ok before data_ok of its previous request",
                     $time, port_name(p));
        end
        pend[p] = 1'b1;
        pend_req[p] = r;
        accept_cycle[p] = cycle;
        // Same line as the access just before, so it must hit
        expect_hit[p] = last_valid && (line_a == last_line) && !r.wr;
        last_line = line_a;
        last_valid = 1'b1;
    endtask

    task automatic retire(input int p, input l2_pkg::word_t rd);
        l2_pkg::l1_req_t r;
        l2_pkg::word_t   exp;
        logic [7:0]      widx;
        r = pend_req[p];
        widx = r.addr[9:2];
        check_q++;
        if (!pend[p]) begin
            err_q++;
            $display("error at %0t: %s port data_ok with no pending request",
                     $time, port_name(p));
            return;
        end
        pend[p] = 1'b0;
        if (r.wr) begin
            for (int b = 0; b < 4; b++) begin
                if (r.wstrb[b]) begin
                    model[widx][8*b +: 8] = r.wdata[8*b +: 8];
                end
            end
        end else begin
            exp = model[widx];
            if (rd !== exp) begin
                err_q++;
                $display("error at %0t: %s port read of %h returned %h, expected %h",
                         $time, port_name(p), r.addr, rd, exp);
            end
            if (expect_hit[p] && (cycle != accept_cycle[p] + 1)) begin
                err_q++;
                $display("error at %0t: %s port read hit at %h took %0d cycles, expected 1",
                         $time, port_name(p), r.addr, cycle - accept_cycle[p]);
            end
        end
    endtask

    always @(posedge clk) begin
        cycle++;
        if (!rst_n) begin
            if (i_addr_ok || i_data_ok || d_addr_ok || d_data_ok) begin
                err_q++;
                $display("error at %0t: handshake output high during reset", $time);
            end
        end else begin
            if (i_data_ok) begin
                retire(0, i_rdata);
            end
            if (d_data_ok) begin
                retire(1, d_rdata);
            end
            if ((i_addr_ok && !i_req) || (d_addr_ok && !d_req)) begin
                err_q++;
                $display("error at %0t: addr_ok on a port with no request", $time);
            end
            if (i_addr_ok && d_req) begin
                err_q++;
                $display("error at %0t: instruction port accepted while data port requested",
                         $time);
            end
            if (d_addr_ok) begin
                note_accept(1, d_l1);
            end
            if (i_addr_ok) begin
                note_accept(0, i_l1);
            end
        end
    end

endmodule

//--- l2_subsystem.sv
module l2_subsystem (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            i_req,
    input  l2_pkg::l1_req_t i_l1,
    input  logic            d_req,
    input  l2_pkg::l1_req_t d_l1,
    output logic            i_addr_ok,
    output logic            i_data_ok,
    output l2_pkg::word_t   i_rdata,
    output logic            d_addr_ok,
    output logic            d_data_ok,
    output l2_pkg::word_t   d_rdata
);

    localparam int index_width = 2;
    localparam int mem_lines_width = 6;
    localparam int mem_latency = 4;

    logic             arb_req;
    l2_pkg::l1_req_t  arb_l1;
    logic             accept;
    logic             done;
    l2_pkg::word_t    rdata;
    logic             mem_req;
    l2_pkg::mem_req_t mem;
    logic             mem_ack;
    l2_pkg::line_t    mem_rdata;

    l2_port_arbiter u_arbiter (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_req     (i_req),
        .i_l1      (i_l1),
        .d_req     (d_req),
        .d_l1      (d_l1),
        .i_addr_ok (i_addr_ok),
        .i_data_ok (i_data_ok),
        .i_rdata   (i_rdata),
        .d_addr_ok (d_addr_ok),
        .d_data_ok (d_data_ok),
        .d_rdata   (d_rdata),
        .req       (arb_req),
        .l1        (arb_l1),
        .accept    (accept),
        .done      (done),
        .rdata     (rdata)
    );

    l2_ctrl #(.index_width(index_width)) u_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (arb_req),
        .l1        (arb_l1),
        .accept    (accept),
        .done      (done),
        .rdata     (rdata),
        .mem_req   (mem_req),
        .mem       (mem),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata)
    );

    l2_backing_mem #(
        .mem_lines_width (mem_lines_width),
        .mem_latency     (mem_latency)
    ) u_mem (
        .clk       (clk),
        .rst_n     (rst_n),
        .mem_req   (mem_req),
        .mem       (mem),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata)
    );

endmodule

//--- l2_backing_mem.sv
module l2_backing_mem #(
    parameter int mem_lines_width = 6,
    parameter int mem_latency = 4
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             mem_req,
    input  l2_pkg::mem_req_t mem,
    output logic             mem_ack,
    output l2_pkg::line_t    mem_rdata
);

    localparam int cnt_width = $clog2(mem_latency) + 1;

    l2_pkg::line_t mem_q [1 << mem_lines_width] = '{default: '0};

    logic [cnt_width-1:0]       cnt;
    logic [mem_lines_width-1:0] line_idx;
    logic                       fire;

    assign line_idx = mem.line_addr[l2_pkg::offset_width + 2 +: mem_lines_width];

    // Last waiting cycle; the ack shows up on the next one
    assign fire = mem_req && !mem_ack && (cnt == cnt_width'(mem_latency - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt     <= '0;
            mem_ack <= 1'b0;
        end else begin
            mem_ack <= fire;
            if (fire || !mem_req || mem_ack) begin
                cnt <= '0;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            mem_rdata <= mem_q[line_idx];
            if (mem.wr) begin
                mem_q[line_idx] <= mem.wdata;
            end
        end
    end

    a_ack_with_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(mem_ack) |-> mem_req);

endmodule

//--- l2_port_arbiter.sv
module l2_port_arbiter (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            i_req,
    input  l2_pkg::l1_req_t i_l1,
    input  logic            d_req,
    input  l2_pkg::l1_req_t d_l1,
    output logic            i_addr_ok,
    output logic            i_data_ok,
    output l2_pkg::word_t   i_rdata,
    output logic            d_addr_ok,
    output logic            d_data_ok,
    output l2_pkg::word_t   d_rdata,
    output logic            req,
    output l2_pkg::l1_req_t l1,
    input  logic            accept,
    input  logic            done,
    input  l2_pkg::word_t   rdata
);

    // 1 when the data port owns the transaction in flight
    logic owner_d;

    // Data port first
    assign req = d_req | i_req;
    assign l1  = d_req ? d_l1 : i_l1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            owner_d <= 1'b0;
        end else if (accept) begin
            owner_d <= d_req;
        end
    end

    assign d_addr_ok = accept & d_req;
    assign i_addr_ok = accept & ~d_req;

    assign d_data_ok = done & owner_d;
    assign i_data_ok = done & ~owner_d;

    assign i_rdata = rdata;
    assign d_rdata = rdata;

    // No second accept right behind the first
    a_one_addr_ok: assert property (@(posedge clk) disable iff (!rst_n)
        (i_addr_ok || d_addr_ok) |=> !(i_addr_ok || d_addr_ok));

endmodule

//--- l2_ctrl.sv
module l2_ctrl #(
    parameter int index_width = 2
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             req,
    input  l2_pkg::l1_req_t  l1,
    output logic             accept,
    output logic             done,
    output l2_pkg::word_t    rdata,
    output logic             mem_req,
    output l2_pkg::mem_req_t mem,
    input  logic             mem_ack,
    input  l2_pkg::line_t    mem_rdata
);

    localparam int tag_width = 32 - index_width - l2_pkg::offset_width - 2;
    localparam int way_width = $clog2(l2_pkg::num_ways);

    typedef enum logic [1:0] {
        st_idle,
        st_lookup,
        st_writeback,
        st_refill
    } ctrl_state_t;

    ctrl_state_t state, state_nxt;
    l2_pkg::l1_req_t rbuf;
    logic ack_q;

    logic [index_width-1:0]          index;
    logic [tag_width-1:0]            tag;
    logic [l2_pkg::offset_width-1:0] offset;

    logic [l2_pkg::num_ways-1:0] hit_way;
    logic                        hit;
    logic [way_width-1:0]        hit_idx;
    logic [way_width-1:0]        victim;
    logic [way_width-1:0]        cur_way;
    logic [tag_width-1:0]        victim_tag;
    logic                        victim_valid;
    logic                        victim_dirty;
    logic                        refill_done;
    l2_pkg::line_t               rline;

    assign offset = rbuf.addr[2 +: l2_pkg::offset_width];
    assign index  = rbuf.addr[l2_pkg::offset_width + 2 +: index_width];
    assign tag    = rbuf.addr[31 -: tag_width];

    always_comb begin
        hit_idx = '0;
        for (int w = 0; w < l2_pkg::num_ways; w++) begin
            if (hit_way[w]) begin
                hit_idx = way_width'(w);
            end
        end
    end

    // Hit way during lookup, victim way while moving lines
    assign cur_way = (state == st_lookup) ? hit_idx : victim;

    assign accept      = (state == st_idle) && req;
    assign done        = (state == st_lookup) && hit;
    assign refill_done = (state == st_refill) && mem_ack;
    assign rdata       = rline[32*offset +: 32];

    always_ff @(posedge clk) begin
        if (accept) begin
            rbuf <= l1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
            ack_q <= 1'b0;
        end else begin
            state <= state_nxt;
            ack_q <= mem_ack;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle:      if (req) state_nxt = st_lookup;
            st_lookup: begin
                if (hit) begin
                    state_nxt = st_idle;
                end else if (victim_valid && victim_dirty) begin
                    state_nxt = st_writeback;
                end else begin
                    state_nxt = st_refill;
                end
            end
            st_writeback: if (mem_ack) state_nxt = st_refill;
            st_refill:    if (mem_ack) state_nxt = st_lookup;
            default:      state_nxt = st_idle;
        endcase
    end

    // One idle cycle between writeback ack and the refill request
    assign mem_req = ((state == st_writeback) || (state == st_refill)) && !ack_q;
    assign mem.line_addr = (state == st_writeback) ?
        {victim_tag, index, {(l2_pkg::offset_width + 2){1'b0}}} :
        {tag, index, {(l2_pkg::offset_width + 2){1'b0}}};
    assign mem.wdata = rline;
    assign mem.wr    = (state == st_writeback);

    l2_tag_array #(.index_width(index_width)) u_tag_array (
        .clk          (clk),
        .rst_n        (rst_n),
        .index        (index),
        .tag          (tag),
        .hit_way      (hit_way),
        .hit          (hit),
        .victim_tag   (victim_tag),
        .victim_valid (victim_valid),
        .victim_dirty (victim_dirty),
        .victim       (victim),
        .fill_we      (refill_done),
        .fill_tag     (tag),
        .dirty_we     (done && rbuf.wr),
        .dirty_way    (hit_idx)
    );

    l2_data_array #(.index_width(index_width)) u_data_array (
        .clk       (clk),
        .index     (index),
        .way       (cur_way),
        .offset    (offset),
        .word_we   (done && rbuf.wr),
        .wdata     (rbuf.wdata),
        .wstrb     (rbuf.wstrb),
        .line_we   (refill_done),
        .fill_line (mem_rdata),
        .rline     (rline)
    );

    l2_plru #(.index_width(index_width)) u_plru (
        .clk       (clk),
        .rst_n     (rst_n),
        .index     (index),
        .touch     (done || refill_done),
        .touch_way (cur_way),
        .victim    (victim)
    );

    // A line sits in at most one way of its set
    a_done_on_hit: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> $onehot(hit_way));

    a_mem_req_held: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req && !mem_ack |=> mem_req && $stable(mem));

endmodule

//--- l2_plru.sv
module l2_plru #(
    parameter  int index_width = 2,
    localparam int way_width = $clog2(l2_pkg::num_ways)
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [index_width-1:0] index,
    input  logic                   touch,
    input  logic [way_width-1:0]   touch_way,
    output logic [way_width-1:0]   victim
);

    localparam int num_sets = 1 << index_width;

    // Bit 0 is the root, bit 1 the left pair, bit 2 the right pair
    logic [num_sets-1:0][2:0] tree_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tree_q <= '0;
        end else if (touch) begin
            tree_q[index][0] <= ~touch_way[1];
            if (touch_way[1]) begin
                tree_q[index][2] <= ~touch_way[0];
            end else begin
                tree_q[index][1] <= ~touch_way[0];
            end
        end
    end

    assign victim = tree_q[index][0] ? {1'b1, tree_q[index][2]} : {1'b0, tree_q[index][1]};

endmodule

//--- l2_data_array.sv
module l2_data_array #(
    parameter  int index_width = 2,
    localparam int way_width = $clog2(l2_pkg::num_ways)
) (
    input  logic                            clk,
    input  logic [index_width-1:0]          index,
    input  logic [way_width-1:0]            way,
    input  logic [l2_pkg::offset_width-1:0] offset,
    input  logic                            word_we,
    input  l2_pkg::word_t                   wdata,
    input  l2_pkg::strb_t                   wstrb,
    input  logic                            line_we,
    input  l2_pkg::line_t                   fill_line,
    output l2_pkg::line_t                   rline
);

    localparam int num_sets = 1 << index_width;

    l2_pkg::line_t data_q [num_sets][l2_pkg::num_ways];

    always_ff @(posedge clk) begin
        if (line_we) begin
            data_q[index][way] <= fill_line;
        end else if (word_we) begin
            // Byte lanes of the addressed word
            for (int b = 0; b < 4; b++) begin
                if (wstrb[b]) begin
                    data_q[index][way][32*offset + 8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

    assign rline = data_q[index][way];

endmodule

//--- l2_tag_array.sv
module l2_tag_array #(
    parameter  int index_width = 2,
    localparam int tag_width = 32 - index_width - l2_pkg::offset_width - 2,
    localparam int way_width = $clog2(l2_pkg::num_ways)
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [index_width-1:0]      index,
    input  logic [tag_width-1:0]        tag,
    output logic [l2_pkg::num_ways-1:0] hit_way,
    output logic                        hit,
    output logic [tag_width-1:0]        victim_tag,
    output logic                        victim_valid,
    output logic                        victim_dirty,
    input  logic [way_width-1:0]        victim,
    input  logic                        fill_we,
    input  logic [tag_width-1:0]        fill_tag,
    input  logic                        dirty_we,
    input  logic [way_width-1:0]        dirty_way
);

    localparam int num_sets = 1 << index_width;

    logic [tag_width-1:0] tag_q [num_sets][l2_pkg::num_ways];
    logic [num_sets-1:0][l2_pkg::num_ways-1:0] valid_q;
    logic [num_sets-1:0][l2_pkg::num_ways-1:0] dirty_q;

    always_ff @(posedge clk) begin
        if (fill_we) begin
            tag_q[index][victim] <= fill_tag;
        end
    end

    // A fill leaves the line valid and clean
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            if (fill_we) begin
                valid_q[index][victim] <= 1'b1;
                dirty_q[index][victim] <= 1'b0;
            end
            if (dirty_we) begin
                dirty_q[index][dirty_way] <= 1'b1;
            end
        end
    end

    always_comb begin
        for (int w = 0; w < l2_pkg::num_ways; w++) begin
            hit_way[w] = valid_q[index][w] && (tag_q[index][w] == tag);
        end
    end

    assign hit = |hit_way;

    assign victim_tag   = tag_q[index][victim];
    assign victim_valid = valid_q[index][victim];
    assign victim_dirty = dirty_q[index][victim];

endmodule

//--- l2_pkg.sv
package l2_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0]  strb_t;

    // Line geometry
    localparam int words_per_line = 4;
    localparam int offset_width = 2;

    typedef logic [32*words_per_line-1:0] line_t;

    // Pseudo-LRU tree is built for exactly four ways
    localparam int num_ways = 4;

    // Request from a first-level client
    typedef struct packed {
        addr_t addr;
        word_t wdata;
        strb_t wstrb;
        logic  wr;
    } l1_req_t;

    // Whole-line request toward main memory
    typedef struct packed {
        addr_t line_addr;
        line_t wdata;
        logic  wr;
    } mem_req_t;

endpackage
